// ==== Bender.yml ====
package:
  name: ccu

sources:
  - include_dirs:
      - common
    files:
      - common/ccu_reg_pkg.sv
      - common/ccu_ctrl_pkg.sv
      - common/ccu_host_if.sv
      - common/ccu_ctrl_if.sv
      - register_file/ccu_axil_slave.sv
      - register_file/ccu_register_file.sv
      - source/ccu_sequencer.sv
      - source/ccu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_ccu.sv

// ==== common/ccu_ctrl_if.sv ====
// Register file to sequencer bus
// Configuration levels, PL update strobes and PL update values
`timescale 1ns/1ps
`include "ccu_macros.svh"

interface ccu_ctrl_if;
  // Configuration and commands from the register file
  logic [`CCU_DATA_WIDTH-1:0]       rslt_len;
  logic [7:0]                       btch_len;
  logic [3:0]                       loaded;
  logic                             start;
  logic                             intr_soft;
  logic                             intr_abort;
  logic                             intr_error;

  // PL update strobes from the sequencer
  logic                             str_clr;
  logic                             dne_set;
  logic                             intr_err_clr;
  logic                             wo_en;
  logic                             wo_rst;

  // Values loaded on wo_en
  logic [`CCU_DATA_WIDTH-1:0]       rslt_prg;
  logic [`CCU_DATA_WIDTH-1:0]       iter_prg;
  logic [`CCU_TIMER_WIDTH-1:0]      iter_tmr;
  logic [`CCU_TIMER_WIDTH-1:0]      iter_lat;
  logic [`CCU_TIMER_WIDTH-1:0]      oper_tmr;
  logic [`CCU_TIMER_WIDTH-1:0]      oper_lat;
  logic [ccu_reg_pkg::STS_WIDTH-1:0] status;

  modport regs (
    output rslt_len, btch_len, loaded, start, intr_soft, intr_abort, intr_error,
    input  str_clr, dne_set, intr_err_clr, wo_en, wo_rst,
    input  rslt_prg, iter_prg, iter_tmr, iter_lat, oper_tmr, oper_lat, status
  );

  modport seq (
    input  rslt_len, btch_len, loaded, start, intr_soft, intr_abort, intr_error,
    output str_clr, dne_set, intr_err_clr, wo_en, wo_rst,
    output rslt_prg, iter_prg, iter_tmr, iter_lat, oper_tmr, oper_lat, status
  );

endinterface

// ==== common/ccu_ctrl_pkg.sv ====
// Sequencer types
// Operation state enum
package ccu_ctrl_pkg;

  // Operation states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    START = 3'd1,
    RUN   = 3'd2,
    DONE  = 3'd3,
    ERROR = 3'd4
  } seq_state_e;

endpackage

// ==== common/ccu_host_if.sv ====
// Host register access bus
// Single-cycle write and read strobes from the AXI-Lite front end
`timescale 1ns/1ps
`include "ccu_macros.svh"

interface ccu_host_if;
  logic                       wr_en;
  ccu_reg_pkg::reg_idx_e      wr_idx;
  logic [`CCU_DATA_WIDTH-1:0] wr_data;
  logic [`CCU_STRB_WIDTH-1:0] wr_strb;
  logic                       rd_en;
  ccu_reg_pkg::reg_idx_e      rd_idx;
  // Valid in the cycle after rd_en
  logic [`CCU_DATA_WIDTH-1:0] rd_data;

  modport slave (
    output wr_en, wr_idx, wr_data, wr_strb, rd_en, rd_idx,
    input  rd_data
  );

  modport regs (
    input  wr_en, wr_idx, wr_data, wr_strb, rd_en, rd_idx,
    output rd_data
  );

endinterface

// ==== common/ccu_macros.svh ====
// Width constants for the central control unit
// Address, data, strobe and timer counter widths
`ifndef CCU_MACROS_SVH
`define CCU_MACROS_SVH

// Byte address covering 16 words
`define CCU_ADDR_WIDTH 6

// Register width and its byte strobe width
`define CCU_DATA_WIDTH 32
`define CCU_STRB_WIDTH (`CCU_DATA_WIDTH / 8)

// Timer and latency counters
`define CCU_TIMER_WIDTH 32

`endif

// ==== common/ccu_reg_pkg.sv ====
// Register map of the control unit
// Word index enum, interrupt bits and status bits
package ccu_reg_pkg;

  // Word index, byte address is four times the index
  typedef enum logic [3:0] {
    REG_RSLT_LEN = 4'd0,
    REG_BTCH_LEN = 4'd1,
    REG_LOADED   = 4'd2,
    REG_OPER_STR = 4'd3,
    REG_OPER_DNE = 4'd4,
    REG_INTR     = 4'd5,
    REG_OPER_STS = 4'd6,
    REG_RSLT_PRG = 4'd7,
    REG_ITER_PRG = 4'd8,
    REG_ITER_TMR = 4'd9,
    REG_ITER_LAT = 4'd10,
    REG_OPER_TMR = 4'd11,
    REG_OPER_LAT = 4'd12
  } reg_idx_e;

  // Fields of REG_INTR
  localparam int INTR_WIDTH     = 3;
  localparam int INTR_SOFT_BIT  = 0;
  localparam int INTR_ABORT_BIT = 1;
  localparam int INTR_ERROR_BIT = 2;

  // Fields of REG_OPER_STS
  localparam int STS_WIDTH      = 5;
  localparam int STS_IDLE_BIT   = 0;
  localparam int STS_BUSY_BIT   = 1;
  localparam int STS_ERROR_BIT  = 2;
  localparam int STS_LOCKED_BIT = 3;
  localparam int STS_VALID_BIT  = 4;

endpackage

// ==== register_file/ccu_axil_slave.sv ====
// AXI-Lite slave front end
// One write or read strobe per transaction, responses held until taken
`timescale 1ns/1ps
`include "ccu_macros.svh"

module ccu_axil_slave (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`CCU_ADDR_WIDTH-1:0] s_axil_awaddr,
  input  logic                       s_axil_awvalid,
  output logic                       s_axil_awready,
  input  logic [`CCU_DATA_WIDTH-1:0] s_axil_wdata,
  input  logic [`CCU_STRB_WIDTH-1:0] s_axil_wstrb,
  input  logic                       s_axil_wvalid,
  output logic                       s_axil_wready,
  output logic [1:0]                 s_axil_bresp,
  output logic                       s_axil_bvalid,
  input  logic                       s_axil_bready,
  input  logic [`CCU_ADDR_WIDTH-1:0] s_axil_araddr,
  input  logic                       s_axil_arvalid,
  output logic                       s_axil_arready,
  output logic [`CCU_DATA_WIDTH-1:0] s_axil_rdata,
  output logic [1:0]                 s_axil_rresp,
  output logic                       s_axil_rvalid,
  input  logic                       s_axil_rready,
  ccu_host_if.slave                  host
);

  // Byte offset bits below the word index
  localparam int OFFS = $clog2(`CCU_STRB_WIDTH);

  logic wr_ack_q;
  logic bvalid_q;
  logic arready_q;
  logic rvalid_q;
  logic wr_acc;
  logic rd_acc;

  // Accept while the previous ready pulse is gone and the response slot is free
  assign wr_acc = s_axil_awvalid && s_axil_wvalid && !wr_ack_q &&
                  (!bvalid_q || s_axil_bready);
  assign rd_acc = s_axil_arvalid && !arready_q && (!rvalid_q || s_axil_rready);

  assign host.wr_en   = wr_acc;
  assign host.wr_idx  = ccu_reg_pkg::reg_idx_e'(s_axil_awaddr[`CCU_ADDR_WIDTH-1:OFFS]);
  assign host.wr_data = s_axil_wdata;
  assign host.wr_strb = s_axil_wstrb;
  assign host.rd_en   = rd_acc;
  assign host.rd_idx  = ccu_reg_pkg::reg_idx_e'(s_axil_araddr[`CCU_ADDR_WIDTH-1:OFFS]);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ack_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      wr_ack_q  <= wr_acc;
      bvalid_q  <= wr_acc || (bvalid_q && !s_axil_bready);
      arready_q <= rd_acc;
      rvalid_q  <= rd_acc || (rvalid_q && !s_axil_rready);
    end
  end

  // Address and data channels are taken together
  assign s_axil_awready = wr_ack_q;
  assign s_axil_wready  = wr_ack_q;
  assign s_axil_bvalid  = bvalid_q;
  assign s_axil_bresp   = 2'b00;   // OKAY
  assign s_axil_arready = arready_q;
  assign s_axil_rvalid  = rvalid_q;
  assign s_axil_rresp   = 2'b00;   // OKAY

  // Read data register lives in the register file and holds until the next read
  assign s_axil_rdata = host.rd_data;

  // Pending responses hold, and read data stays put while rvalid waits
  assert property (@(posedge clk) disable iff (rst)
    bvalid_q && !s_axil_bready |=> bvalid_q);
  assert property (@(posedge clk) disable iff (rst)
    rvalid_q && !s_axil_rready |=> rvalid_q && $stable(s_axil_rdata));

endmodule

// ==== register_file/ccu_register_file.sv ====
// Control and status register storage
// Byte strobe writes, PL update paths with host priority, read mux
`timescale 1ns/1ps
`include "ccu_macros.svh"

module ccu_register_file (
  input  logic     clk,
  input  logic     rst,
  ccu_host_if.regs host,
  ccu_ctrl_if.regs ctrl
);

  localparam int DW = `CCU_DATA_WIDTH;
  localparam int TW = `CCU_TIMER_WIDTH;

  // Host-writable registers
  logic [DW-1:0]                      rslt_len_q;
  logic [7:0]                         btch_len_q;
  logic [3:0]                         loaded_q;
  logic                               str_q;
  logic                               dne_q;
  logic [ccu_reg_pkg::INTR_WIDTH-1:0] intr_q;

  // PL-written registers
  logic [ccu_reg_pkg::STS_WIDTH-1:0]  sts_q;
  logic [DW-1:0]                      rslt_prg_q;
  logic [DW-1:0]                      iter_prg_q;
  logic [TW-1:0]                      iter_tmr_q;
  logic [TW-1:0]                      iter_lat_q;
  logic [TW-1:0]                      oper_tmr_q;
  logic [TW-1:0]                      oper_lat_q;

  // Word view of the whole map, shared by the read and write paths
  logic [DW-1:0]                      view [16];
  logic [DW-1:0]                      wr_word;

  function automatic logic [DW-1:0] apply_strb(
    input logic [DW-1:0]              old_word,
    input logic [DW-1:0]              new_word,
    input logic [`CCU_STRB_WIDTH-1:0] strb
  );
    logic [DW-1:0] res;
    res = old_word;
    for (int b = 0; b < `CCU_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Unmapped words read as zero
  always_comb begin
    view = '{default: '0};
    view[ccu_reg_pkg::REG_RSLT_LEN]             = rslt_len_q;
    view[ccu_reg_pkg::REG_BTCH_LEN][7:0]        = btch_len_q;
    view[ccu_reg_pkg::REG_LOADED][3:0]          = loaded_q;
    view[ccu_reg_pkg::REG_OPER_STR][0]          = str_q;
    view[ccu_reg_pkg::REG_OPER_DNE][0]          = dne_q;
    view[ccu_reg_pkg::REG_INTR][ccu_reg_pkg::INTR_WIDTH-1:0]    = intr_q;
    view[ccu_reg_pkg::REG_OPER_STS][ccu_reg_pkg::STS_WIDTH-1:0] = sts_q;
    view[ccu_reg_pkg::REG_RSLT_PRG]             = rslt_prg_q;
    view[ccu_reg_pkg::REG_ITER_PRG]             = iter_prg_q;
    view[ccu_reg_pkg::REG_ITER_TMR][TW-1:0]     = iter_tmr_q;
    view[ccu_reg_pkg::REG_ITER_LAT][TW-1:0]     = iter_lat_q;
    view[ccu_reg_pkg::REG_OPER_TMR][TW-1:0]     = oper_tmr_q;
    view[ccu_reg_pkg::REG_OPER_LAT][TW-1:0]     = oper_lat_q;
  end

  assign wr_word = apply_strb(view[host.wr_idx], host.wr_data, host.wr_strb);

  always_ff @(posedge clk) begin
    if (rst) begin
      rslt_len_q <= '0;
      btch_len_q <= '0;
      loaded_q   <= '0;
      str_q      <= 1'b0;
      dne_q      <= 1'b0;
      intr_q     <= '0;
      sts_q      <= '0;
      sts_q[ccu_reg_pkg::STS_IDLE_BIT] <= 1'b1;
      rslt_prg_q <= '0;
      iter_prg_q <= '0;
      iter_tmr_q <= '0;
      iter_lat_q <= '0;
      oper_tmr_q <= '0;
      oper_lat_q <= '0;
    end else begin
      sts_q <= ctrl.status;
      if (ctrl.str_clr) begin
        str_q <= 1'b0;
      end
      if (ctrl.dne_set) begin
        dne_q <= 1'b1;
      end
      if (ctrl.intr_err_clr) begin
        intr_q[ccu_reg_pkg::INTR_ERROR_BIT] <= 1'b0;
      end
      if (ctrl.wo_rst) begin
        rslt_prg_q <= '0;
        iter_prg_q <= '0;
        iter_tmr_q <= '0;
        iter_lat_q <= '0;
        oper_tmr_q <= '0;
        oper_lat_q <= '0;
      end else if (ctrl.wo_en) begin
        rslt_prg_q <= ctrl.rslt_prg;
        iter_prg_q <= ctrl.iter_prg;
        iter_tmr_q <= ctrl.iter_tmr;
        iter_lat_q <= ctrl.iter_lat;
        oper_tmr_q <= ctrl.oper_tmr;
        oper_lat_q <= ctrl.oper_lat;
      end
      // Host write comes last so it overrides a PL update in the same cycle
      if (host.wr_en) begin
        case (host.wr_idx)
          ccu_reg_pkg::REG_RSLT_LEN: rslt_len_q <= wr_word;
          ccu_reg_pkg::REG_BTCH_LEN: btch_len_q <= wr_word[7:0];
          ccu_reg_pkg::REG_LOADED:   loaded_q   <= wr_word[3:0];
          ccu_reg_pkg::REG_OPER_STR: str_q      <= wr_word[0];
          ccu_reg_pkg::REG_OPER_DNE: dne_q      <= wr_word[0];
          ccu_reg_pkg::REG_INTR:     intr_q     <= wr_word[ccu_reg_pkg::INTR_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read data answers one cycle after rd_en and holds until the next read
  always_ff @(posedge clk) begin
    if (host.rd_en) begin
      host.rd_data <= view[host.rd_idx];
    end
  end

  assign ctrl.rslt_len   = rslt_len_q;
  assign ctrl.btch_len   = btch_len_q;
  assign ctrl.loaded     = loaded_q;
  assign ctrl.start      = str_q;
  assign ctrl.intr_soft  = intr_q[ccu_reg_pkg::INTR_SOFT_BIT];
  assign ctrl.intr_abort = intr_q[ccu_reg_pkg::INTR_ABORT_BIT];
  assign ctrl.intr_error = intr_q[ccu_reg_pkg::INTR_ERROR_BIT];

  // Sequencer never loads and clears the progress registers together
  assert property (@(posedge clk) disable iff (rst) !(ctrl.wo_en && ctrl.wo_rst));

endmodule

// ==== sim/tb_ccu.sv ====
// Directed testbench for the central control unit
// AXI-Lite access tasks, value check, timeout counter and six tests
`timescale 1ns/1ps
`include "ccu_macros.svh"

module tb_ccu;

  localparam int MAX_CYCLES = 2000;

  logic                       clk;
  logic                       rst;
  logic [`CCU_ADDR_WIDTH-1:0] s_axil_awaddr;
  logic                       s_axil_awvalid;
  logic                       s_axil_awready;
  logic [`CCU_DATA_WIDTH-1:0] s_axil_wdata;
  logic [`CCU_STRB_WIDTH-1:0] s_axil_wstrb;
  logic                       s_axil_wvalid;
  logic                       s_axil_wready;
  logic [1:0]                 s_axil_bresp;
  logic                       s_axil_bvalid;
  logic                       s_axil_bready;
  logic [`CCU_ADDR_WIDTH-1:0] s_axil_araddr;
  logic                       s_axil_arvalid;
  logic                       s_axil_arready;
  logic [`CCU_DATA_WIDTH-1:0] s_axil_rdata;
  logic [1:0]                 s_axil_rresp;
  logic                       s_axil_rvalid;
  logic                       s_axil_rready;
  logic                       result_strobe;
  logic                       busy;
  int                         cycle_count = 0;

  ccu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Ends a run that stops making progress
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped at first mismatch");
    end
  endtask

  // Address and data together, response taken in the ready cycle
  task automatic axil_write(input logic [3:0] idx, input logic [31:0] data,
                            input logic [3:0] strb);
    s_axil_awaddr  = {idx, 2'b00};
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    @(negedge clk);
    while (!s_axil_awready) @(negedge clk);
    check_value("s_axil_wready", s_axil_wready, 1);
    check_value("s_axil_bvalid", s_axil_bvalid, 1);
    check_value("s_axil_bresp", s_axil_bresp, 0);
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] idx, output logic [31:0] data);
    s_axil_araddr  = {idx, 2'b00};
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b1;
    @(negedge clk);
    while (!s_axil_arready) @(negedge clk);
    check_value("s_axil_rvalid", s_axil_rvalid, 1);
    check_value("s_axil_rresp", s_axil_rresp, 0);
    data = s_axil_rdata;
    @(negedge clk);
    s_axil_arvalid = 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] idx, input logic [31:0] expected,
                             input string name);
    logic [31:0] data;
    axil_read(idx, data);
    check_value(name, data, expected);
  endtask

  // Status lags the sequencer by a cycle, so poll it
  task automatic wait_status_bit(input int pos, input logic value);
    logic [31:0] data;
    axil_read(ccu_reg_pkg::REG_OPER_STS, data);
    while (data[pos] !== value) axil_read(ccu_reg_pkg::REG_OPER_STS, data);
  endtask

  task automatic pulse_results(input int count);
    repeat (count) begin
      result_strobe = 1'b1;
      @(negedge clk);
      result_strobe = 1'b0;
      repeat (3) @(negedge clk);
    end
  endtask

  // START lasts one cycle before RUN takes strobes
  task automatic start_operation();
    axil_write(ccu_reg_pkg::REG_OPER_STR, 32'h1, 4'hf);
    while (!busy) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic test_reset_state();
    for (int i = 0; i < 16; i++) begin
      read_expect(i[3:0], (i == ccu_reg_pkg::REG_OPER_STS) ?
                  (32'h1 << ccu_reg_pkg::STS_IDLE_BIT) : 32'h0, $sformatf("reg[%0d]", i));
    end
    check_value("busy", busy, 0);
  endtask

  task automatic test_register_access();
    axil_write(ccu_reg_pkg::REG_RSLT_LEN, 32'h1234_5678, 4'hf);
    read_expect(ccu_reg_pkg::REG_RSLT_LEN, 32'h1234_5678, "rslt_len full");
    // Bytes 0 and 2 only
    axil_write(ccu_reg_pkg::REG_RSLT_LEN, 32'haabb_ccdd, 4'b0101);
    read_expect(ccu_reg_pkg::REG_RSLT_LEN, 32'h12bb_56dd, "rslt_len strb 0101");
    axil_write(ccu_reg_pkg::REG_RSLT_LEN, 32'h0000_0000, 4'b1010);
    read_expect(ccu_reg_pkg::REG_RSLT_LEN, 32'h00bb_00dd, "rslt_len strb 1010");
    axil_write(ccu_reg_pkg::REG_OPER_LAT, 32'hffff_ffff, 4'hf);
    read_expect(ccu_reg_pkg::REG_OPER_LAT, 32'h0, "oper_lat after host write");
    axil_write(4'd14, 32'hffff_ffff, 4'hf);
    read_expect(4'd14, 32'h0, "unmapped reg[14]");
  endtask

  task automatic test_full_operation();
    logic [31:0] data;
    logic [31:0] iter_lat;
    logic [31:0] oper_lat;
    axil_write(ccu_reg_pkg::REG_RSLT_LEN, 32'd3, 4'hf);
    axil_write(ccu_reg_pkg::REG_BTCH_LEN, 32'd2, 4'hf);
    axil_write(ccu_reg_pkg::REG_LOADED, 32'hf, 4'hf);
    start_operation();
    pulse_results(6);
    axil_read(ccu_reg_pkg::REG_OPER_DNE, data);
    while (data !== 32'h1) axil_read(ccu_reg_pkg::REG_OPER_DNE, data);
    check_value("busy", busy, 0);
    read_expect(ccu_reg_pkg::REG_RSLT_PRG, 32'd6, "rslt_prg");
    read_expect(ccu_reg_pkg::REG_ITER_PRG, 32'd2, "iter_prg");
    read_expect(ccu_reg_pkg::REG_OPER_STR, 32'd0, "oper_str");
    read_expect(ccu_reg_pkg::REG_OPER_STS, (32'h1 << ccu_reg_pkg::STS_IDLE_BIT) |
                (32'h1 << ccu_reg_pkg::STS_VALID_BIT), "oper_sts");
    axil_read(ccu_reg_pkg::REG_ITER_LAT, iter_lat);
    axil_read(ccu_reg_pkg::REG_OPER_LAT, oper_lat);
    check_value("iter_lat nonzero", iter_lat != 0, 1);
    check_value("iter_lat <= oper_lat", iter_lat <= oper_lat, 1);
  endtask

  task automatic test_missing_loaded();
    // Weight is bit 3
    axil_write(ccu_reg_pkg::REG_LOADED, 32'h7, 4'hf);
    axil_write(ccu_reg_pkg::REG_OPER_STR, 32'h1, 4'hf);
    wait_status_bit(ccu_reg_pkg::STS_ERROR_BIT, 1'b1);
    read_expect(ccu_reg_pkg::REG_OPER_STR, 32'd0, "oper_str after error");
    axil_write(ccu_reg_pkg::REG_INTR, 32'h1 << ccu_reg_pkg::INTR_ERROR_BIT, 4'hf);
    wait_status_bit(ccu_reg_pkg::STS_IDLE_BIT, 1'b1);
    wait_status_bit(ccu_reg_pkg::STS_ERROR_BIT, 1'b0);
    read_expect(ccu_reg_pkg::REG_INTR, 32'd0, "intr after error clear");
  endtask

  task automatic test_soft_abort();
    axil_write(ccu_reg_pkg::REG_LOADED, 32'hf, 4'hf);
    start_operation();
    pulse_results(2);
    axil_write(ccu_reg_pkg::REG_INTR, 32'h1 << ccu_reg_pkg::INTR_SOFT_BIT, 4'hf);
    wait_status_bit(ccu_reg_pkg::STS_LOCKED_BIT, 1'b1);
    // Would end the first iteration if counted
    pulse_results(1);
    read_expect(ccu_reg_pkg::REG_RSLT_PRG, 32'd0, "rslt_prg while soft");
    axil_write(ccu_reg_pkg::REG_INTR, (32'h1 << ccu_reg_pkg::INTR_SOFT_BIT) |
               (32'h1 << ccu_reg_pkg::INTR_ABORT_BIT), 4'hf);
    wait_status_bit(ccu_reg_pkg::STS_ERROR_BIT, 1'b1);
    check_value("busy", busy, 0);
    axil_write(ccu_reg_pkg::REG_INTR, 32'h1 << ccu_reg_pkg::INTR_ERROR_BIT, 4'hf);
    wait_status_bit(ccu_reg_pkg::STS_IDLE_BIT, 1'b1);
  endtask

  task automatic test_back_pressure();
    logic [31:0] first_data;
    axil_write(ccu_reg_pkg::REG_BTCH_LEN, 32'h5a, 4'hf);
    // First write left without a response handshake
    s_axil_awaddr  = {4'(ccu_reg_pkg::REG_RSLT_LEN), 2'b00};
    s_axil_wdata   = 32'h1111_1111;
    s_axil_wstrb   = 4'hf;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b0;
    @(negedge clk);
    while (!s_axil_awready) @(negedge clk);
    @(negedge clk);
    s_axil_wdata = 32'h2222_2222;
    repeat (4) begin
      @(negedge clk);
      check_value("s_axil_bvalid held", s_axil_bvalid, 1);
      check_value("s_axil_awready blocked", s_axil_awready, 0);
    end
    read_expect(ccu_reg_pkg::REG_RSLT_LEN, 32'h1111_1111, "rslt_len before bready");
    s_axil_bready = 1'b1;
    @(negedge clk);
    check_value("s_axil_awready after bready", s_axil_awready, 1);
    check_value("s_axil_bvalid second", s_axil_bvalid, 1);
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    read_expect(ccu_reg_pkg::REG_RSLT_LEN, 32'h2222_2222, "rslt_len after bready");
    // Same check on the read channel
    s_axil_araddr  = {4'(ccu_reg_pkg::REG_RSLT_LEN), 2'b00};
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b0;
    @(negedge clk);
    while (!s_axil_arready) @(negedge clk);
    first_data = s_axil_rdata;
    check_value("s_axil_rdata first", first_data, 32'h2222_2222);
    @(negedge clk);
    s_axil_araddr = {4'(ccu_reg_pkg::REG_BTCH_LEN), 2'b00};
    repeat (4) begin
      @(negedge clk);
      check_value("s_axil_rvalid held", s_axil_rvalid, 1);
      check_value("s_axil_arready blocked", s_axil_arready, 0);
      check_value("s_axil_rdata held", s_axil_rdata, first_data);
    end
    s_axil_rready = 1'b1;
    @(negedge clk);
    check_value("s_axil_arready after rready", s_axil_arready, 1);
    check_value("s_axil_rdata second", s_axil_rdata, 32'h5a);
    @(negedge clk);
    s_axil_arvalid = 1'b0;
  endtask

  initial begin
    rst            = 1'b1;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    result_strobe  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_register_access();
    test_full_operation();
    test_missing_loaded();
    test_soft_abort();
    test_back_pressure();
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== source/ccu_sequencer.sv ====
// Operation sequencer
// State machine, result and iteration counters, timers and status
`timescale 1ns/1ps
`include "ccu_macros.svh"

module ccu_sequencer (
  input  logic    clk,
  input  logic    rst,
  ccu_ctrl_if.seq ctrl,
  input  logic    result_strobe,
  output logic    busy
);

  localparam int DW = `CCU_DATA_WIDTH;
  localparam int TW = `CCU_TIMER_WIDTH;

  ccu_ctrl_pkg::seq_state_e state_q;
  ccu_ctrl_pkg::seq_state_e state_d;

  logic [DW-1:0] rslt_cnt_q;
  logic [DW-1:0] rslt_prg_q;
  logic [DW-1:0] iter_prg_q;
  logic [TW-1:0] iter_tmr_q;
  logic [TW-1:0] iter_lat_q;
  logic [TW-1:0] oper_tmr_q;
  logic [TW-1:0] oper_lat_q;
  logic          valid_q;
  logic          cfg_ok;
  logic          take;
  logic          iter_end;
  logic          last_iter;

  // Everything loaded and both lengths programmed
  assign cfg_ok = (&ctrl.loaded) && (ctrl.rslt_len != '0) && (ctrl.btch_len != '0);

  // Strobes count only while running, and are dropped while paused
  assign take      = (state_q == ccu_ctrl_pkg::RUN) && result_strobe &&
                     !ctrl.intr_soft && !ctrl.intr_abort;
  assign iter_end  = take && (rslt_cnt_q + 1'b1 == ctrl.rslt_len);
  assign last_iter = iter_end &&
                     (iter_prg_q + 1'b1 == {{(DW-8){1'b0}}, ctrl.btch_len});

  always_comb begin
    state_d = state_q;
    case (state_q)
      ccu_ctrl_pkg::IDLE: begin
        if (ctrl.start) begin
          state_d = cfg_ok ? ccu_ctrl_pkg::START : ccu_ctrl_pkg::ERROR;
        end
      end
      ccu_ctrl_pkg::START: state_d = ccu_ctrl_pkg::RUN;
      ccu_ctrl_pkg::RUN: begin
        if (ctrl.intr_abort) begin
          state_d = ccu_ctrl_pkg::ERROR;
        end else if (last_iter) begin
          state_d = ccu_ctrl_pkg::DONE;
        end
      end
      ccu_ctrl_pkg::DONE: state_d = ccu_ctrl_pkg::IDLE;
      ccu_ctrl_pkg::ERROR: begin
        if (ctrl.intr_error) begin
          state_d = ccu_ctrl_pkg::IDLE;
        end
      end
      default: state_d = ccu_ctrl_pkg::IDLE;
    endcase
  end

  // PL update strobes
  assign ctrl.str_clr      = (state_q == ccu_ctrl_pkg::IDLE) && ctrl.start;
  assign ctrl.wo_rst       = (state_q == ccu_ctrl_pkg::START);
  assign ctrl.dne_set      = (state_q == ccu_ctrl_pkg::DONE);
  assign ctrl.wo_en        = iter_end || (state_q == ccu_ctrl_pkg::DONE);
  assign ctrl.intr_err_clr = (state_q == ccu_ctrl_pkg::ERROR) && ctrl.intr_error;

  // Values as they stand after this cycle, loaded on wo_en
  assign ctrl.rslt_prg = rslt_prg_q + {{(DW-1){1'b0}}, take};
  assign ctrl.iter_prg = iter_prg_q + {{(DW-1){1'b0}}, iter_end};
  assign ctrl.iter_tmr = iter_tmr_q;
  assign ctrl.iter_lat = iter_end ? iter_tmr_q + 1'b1 : iter_lat_q;
  assign ctrl.oper_tmr = oper_tmr_q;
  assign ctrl.oper_lat = (state_q == ccu_ctrl_pkg::DONE) ? oper_tmr_q : oper_lat_q;

  always_ff @(posedge clk) begin
    if (rst || state_q == ccu_ctrl_pkg::START) begin
      rslt_cnt_q <= '0;
      rslt_prg_q <= '0;
      iter_prg_q <= '0;
      iter_tmr_q <= '0;
      iter_lat_q <= '0;
      oper_tmr_q <= '0;
      oper_lat_q <= '0;
    end else begin
      rslt_prg_q <= ctrl.rslt_prg;
      iter_prg_q <= ctrl.iter_prg;
      iter_lat_q <= ctrl.iter_lat;
      oper_lat_q <= ctrl.oper_lat;
      if (take) begin
        rslt_cnt_q <= iter_end ? '0 : rslt_cnt_q + 1'b1;
      end
      if (state_q == ccu_ctrl_pkg::RUN) begin
        iter_tmr_q <= iter_end ? '0 : iter_tmr_q + 1'b1;
        oper_tmr_q <= oper_tmr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ccu_ctrl_pkg::IDLE;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ccu_ctrl_pkg::START) begin
        valid_q <= 1'b0;
      end else if (state_q == ccu_ctrl_pkg::DONE) begin
        valid_q <= 1'b1;
      end
    end
  end

  assign busy = (state_q == ccu_ctrl_pkg::START) || (state_q == ccu_ctrl_pkg::RUN) ||
                (state_q == ccu_ctrl_pkg::DONE);

  always_comb begin
    ctrl.status = '0;
    ctrl.status[ccu_reg_pkg::STS_IDLE_BIT]   = (state_q == ccu_ctrl_pkg::IDLE);
    ctrl.status[ccu_reg_pkg::STS_BUSY_BIT]   = busy;
    ctrl.status[ccu_reg_pkg::STS_ERROR_BIT]  = (state_q == ccu_ctrl_pkg::ERROR);
    ctrl.status[ccu_reg_pkg::STS_LOCKED_BIT] = (state_q == ccu_ctrl_pkg::RUN) && ctrl.intr_soft;
    ctrl.status[ccu_reg_pkg::STS_VALID_BIT]  = valid_q;
  end

endmodule

// ==== source/ccu_top.sv ====
// Central control unit top level
// AXI-Lite front end, register file and operation sequencer
`timescale 1ns/1ps
`include "ccu_macros.svh"

module ccu_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`CCU_ADDR_WIDTH-1:0] s_axil_awaddr,
  input  logic                       s_axil_awvalid,
  output logic                       s_axil_awready,
  input  logic [`CCU_DATA_WIDTH-1:0] s_axil_wdata,
  input  logic [`CCU_STRB_WIDTH-1:0] s_axil_wstrb,
  input  logic                       s_axil_wvalid,
  output logic                       s_axil_wready,
  output logic [1:0]                 s_axil_bresp,
  output logic                       s_axil_bvalid,
  input  logic                       s_axil_bready,
  input  logic [`CCU_ADDR_WIDTH-1:0] s_axil_araddr,
  input  logic                       s_axil_arvalid,
  output logic                       s_axil_arready,
  output logic [`CCU_DATA_WIDTH-1:0] s_axil_rdata,
  output logic [1:0]                 s_axil_rresp,
  output logic                       s_axil_rvalid,
  input  logic                       s_axil_rready,
  input  logic                       result_strobe,
  output logic                       busy
);

  ccu_host_if host_bus ();
  ccu_ctrl_if ctrl_bus ();

  ccu_axil_slave i_axil_slave (
    .clk            (clk),
    .rst            (rst),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .host           (host_bus.slave)
  );

  ccu_register_file i_register_file (
    .clk  (clk),
    .rst  (rst),
    .host (host_bus.regs),
    .ctrl (ctrl_bus.regs)
  );

  ccu_sequencer i_sequencer (
    .clk           (clk),
    .rst           (rst),
    .ctrl          (ctrl_bus.seq),
    .result_strobe (result_strobe),
    .busy          (busy)
  );

endmodule

// ==== sources.f ====
+incdir+common
common/ccu_reg_pkg.sv
common/ccu_ctrl_pkg.sv
common/ccu_host_if.sv
common/ccu_ctrl_if.sv
register_file/ccu_axil_slave.sv
register_file/ccu_register_file.sv
source/ccu_sequencer.sv
source/ccu_top.sv
sim/tb_ccu.sv
